// File: rtl/banked_mem_pkg.sv
`default_nettype none

package banked_mem_pkg;

    // --------------------
    // default sizes
    // --------------------
    localparam int DATA_W    = 16;
    localparam int BANKS     = 16;
    localparam int DEPTH     = 128;
    localparam int LANES_DEF = 16;             // 4 and 8 lanes also supported

    localparam int BANK_W = $clog2(BANKS);     // 4 bits
    localparam int ADDR_W = $clog2(DEPTH);     // 7 bits

    // --------------------
    // types
    // --------------------
    typedef logic [DATA_W-1:0] data_t;         // one stored word
    typedef logic [BANK_W-1:0] bank_idx_t;     // which bank
    typedef logic [ADDR_W-1:0] addr_t;         // word inside a bank

endpackage

`default_nettype wire

// File: rtl/lane_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lane_req_if #(
    parameter int LANES = banked_mem_pkg::LANES_DEF
);

    // level enables, sampled every rising edge
    logic rd_en;
    logic wr_en;

    // --------------------
    // per-lane read request
    // --------------------
    banked_mem_pkg::bank_idx_t rd_bank [LANES];
    banked_mem_pkg::addr_t     rd_addr [LANES];

    // --------------------
    // per-lane write request
    // --------------------
    banked_mem_pkg::bank_idx_t wr_bank [LANES];
    banked_mem_pkg::addr_t     wr_addr [LANES];
    banked_mem_pkg::data_t     wr_data [LANES];

    modport src (
        output rd_en,
        output wr_en,
        output rd_bank,
        output rd_addr,
        output wr_bank,
        output wr_addr,
        output wr_data
    );

    // storage side, read address only (bank match happens in the crossbar)
    modport bank (
        input wr_en,
        input wr_bank,
        input wr_addr,
        input wr_data,
        input rd_addr
    );

    modport xbar (
        input rd_en,
        input rd_bank,
        input rd_addr
    );

endinterface

`default_nettype wire

// File: rtl/mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
    parameter int LANES   = banked_mem_pkg::LANES_DEF,
    parameter int BANK_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    lane_req_if.bank              req,
    output banked_mem_pkg::data_t bank_rd_word [LANES]
);

    localparam banked_mem_pkg::bank_idx_t MY_BANK = banked_mem_pkg::bank_idx_t'(BANK_ID);

    banked_mem_pkg::data_t mem [banked_mem_pkg::DEPTH];

    logic [LANES-1:0] lane_hit;    // lane targets this bank
    logic [LANES-1:0] lane_keep;   // lane survives the priority merge

    // --------------------
    // write merge
    // --------------------
    // a lane only writes if no higher lane hits the same word in this bank,
    // so each word sees at most one write per cycle

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_hit[l] = req.wr_en && (req.wr_bank[l] == MY_BANK);
        end
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_keep[l] = lane_hit[l];
            for (int h = l + 1; h < LANES; h++) begin
                if (lane_hit[h] && (req.wr_addr[h] == req.wr_addr[l])) begin
                    lane_keep[l] = 1'b0;    // shadowed by higher lane
                end
            end
        end
    end

    // --------------------
    // storage
    // --------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int w = 0; w < banked_mem_pkg::DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else begin
            // low to high, highest lane lands last
            for (int l = 0; l < LANES; l++) begin
                if (lane_keep[l]) begin
                    mem[req.wr_addr[l]] <= req.wr_data[l];
                end
            end
        end
    end

    // --------------------
    // read words
    // --------------------
    // every lane sees its word here; the crossbar picks the bank

    for (genvar l = 0; l < LANES; l++) begin : g_rd
        assign bank_rd_word[l] = mem[req.rd_addr[l]];    // pre-edge contents
    end

endmodule

`default_nettype wire

// File: rtl/read_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module read_crossbar #(
    parameter int LANES = banked_mem_pkg::LANES_DEF
) (
    input  logic                      clk,
    input  logic                      rst,
    lane_req_if.xbar                  req,
    input  banked_mem_pkg::data_t     bank_words [banked_mem_pkg::BANKS][LANES],
    output banked_mem_pkg::data_t     rd_data [LANES],
    output banked_mem_pkg::bank_idx_t rd_bank_out [LANES],
    output banked_mem_pkg::addr_t     rd_addr_out [LANES],
    output logic                      rd_valid
);

    banked_mem_pkg::data_t sel_word [LANES];

    // --------------------
    // bank select
    // --------------------

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            sel_word[l] = bank_words[req.rd_bank[l]][l];
        end
    end

    // --------------------
    // output registers
    // --------------------
    // zeros when no read is active, so an idle cycle clears the outputs

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
            for (int l = 0; l < LANES; l++) begin
                rd_data[l]     <= '0;
                rd_bank_out[l] <= '0;
                rd_addr_out[l] <= '0;
            end
        end else if (req.rd_en) begin
            rd_valid <= 1'b1;
            for (int l = 0; l < LANES; l++) begin
                rd_data[l]     <= sel_word[l];
                rd_bank_out[l] <= req.rd_bank[l];    // index echo
                rd_addr_out[l] <= req.rd_addr[l];
            end
        end else begin
            rd_valid <= 1'b0;
            for (int l = 0; l < LANES; l++) begin
                rd_data[l]     <= '0;
                rd_bank_out[l] <= '0;
                rd_addr_out[l] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/banked_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module banked_mem_top #(
    parameter int LANES = banked_mem_pkg::LANES_DEF
) (
    input  logic                      clk,
    input  logic                      rst,

    // read group
    input  logic                      rd_en,
    input  banked_mem_pkg::bank_idx_t rd_bank [LANES],
    input  banked_mem_pkg::addr_t     rd_addr [LANES],

    // write group
    input  logic                      wr_en,
    input  banked_mem_pkg::bank_idx_t wr_bank [LANES],
    input  banked_mem_pkg::addr_t     wr_addr [LANES],
    input  banked_mem_pkg::data_t     wr_data [LANES],

    // registered read results, one cycle after rd_en
    output banked_mem_pkg::data_t     rd_data [LANES],
    output banked_mem_pkg::bank_idx_t rd_bank_out [LANES],
    output banked_mem_pkg::addr_t     rd_addr_out [LANES],
    output logic                      rd_valid
);

    // --------------------
    // request bundle
    // --------------------

    lane_req_if #(
        .LANES (LANES)
    ) req ();

    assign req.rd_en   = rd_en;
    assign req.wr_en   = wr_en;
    assign req.rd_bank = rd_bank;
    assign req.rd_addr = rd_addr;
    assign req.wr_bank = wr_bank;
    assign req.wr_addr = wr_addr;
    assign req.wr_data = wr_data;

    // per bank, per lane word at that lane's read address
    banked_mem_pkg::data_t bank_words [banked_mem_pkg::BANKS][LANES];

    // --------------------
    // banks
    // --------------------

    for (genvar b = 0; b < banked_mem_pkg::BANKS; b++) begin : g_bank
        mem_bank #(
            .LANES   (LANES),
            .BANK_ID (b)
        ) u_bank (
            .clk          (clk),
            .rst          (rst),
            .req          (req.bank),
            .bank_rd_word (bank_words[b])
        );
    end

    // --------------------
    // read path
    // --------------------

    read_crossbar #(
        .LANES (LANES)
    ) u_xbar (
        .clk         (clk),
        .rst         (rst),
        .req         (req.xbar),
        .bank_words  (bank_words),
        .rd_data     (rd_data),
        .rd_bank_out (rd_bank_out),
        .rd_addr_out (rd_addr_out),
        .rd_valid    (rd_valid)
    );

endmodule

`default_nettype wire

// File: dv/banked_mem_tb_check.svh
`ifndef BANKED_MEM_TB_CHECK_SVH
`define BANKED_MEM_TB_CHECK_SVH

// --------------------
// reference model
// --------------------

banked_mem_pkg::data_t     model_mem [banked_mem_pkg::BANKS][banked_mem_pkg::DEPTH];
bit                        exp_valid;
banked_mem_pkg::data_t     exp_data [LANES];
banked_mem_pkg::bank_idx_t exp_bank [LANES];
banked_mem_pkg::addr_t     exp_addr [LANES];

task automatic model_clear();
    for (int b = 0; b < banked_mem_pkg::BANKS; b++) begin
        for (int w = 0; w < banked_mem_pkg::DEPTH; w++) begin
            model_mem[b][w] = '0;
        end
    end
    exp_valid = 1'b0;
    for (int l = 0; l < LANES; l++) begin
        exp_data[l] = '0;
        exp_bank[l] = '0;
        exp_addr[l] = '0;
    end
endtask

// read before write, so a same-cycle hit sees the old word
task automatic model_step();
    exp_valid = rd_en;
    for (int l = 0; l < LANES; l++) begin
        exp_data[l] = rd_en ? model_mem[rd_bank[l]][rd_addr[l]] : '0;
        exp_bank[l] = rd_en ? rd_bank[l] : '0;
        exp_addr[l] = rd_en ? rd_addr[l] : '0;
    end
    if (wr_en) begin
        for (int l = 0; l < LANES; l++) begin
            model_mem[wr_bank[l]][wr_addr[l]] = wr_data[l];    // highest lane lands last
        end
    end
endtask

// --------------------
// compare tasks
// --------------------

task automatic check_data(input string name, input int lane,
                          input banked_mem_pkg::data_t got, input banked_mem_pkg::data_t exp);
    if (got !== exp) begin
        err_count++;
        $display("ERROR: %s[%0d] got 0x%h expected 0x%h", name, lane, got, exp);
        fail_stop();
    end
endtask

task automatic check_bank(input string name, input int lane,
                          input banked_mem_pkg::bank_idx_t got,
                          input banked_mem_pkg::bank_idx_t exp);
    if (got !== exp) begin
        err_count++;
        $display("ERROR: %s[%0d] got 0x%h expected 0x%h", name, lane, got, exp);
        fail_stop();
    end
endtask

task automatic check_addr(input string name, input int lane,
                          input banked_mem_pkg::addr_t got, input banked_mem_pkg::addr_t exp);
    if (got !== exp) begin
        err_count++;
        $display("ERROR: %s[%0d] got 0x%h expected 0x%h", name, lane, got, exp);
        fail_stop();
    end
endtask

task automatic check_valid(input bit got, input bit exp);
    if (got !== exp) begin
        err_count++;
        $display("ERROR: rd_valid got 0x%h expected 0x%h", got, exp);
        fail_stop();
    end
endtask

// --------------------
// stimulus source
// --------------------

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);    // one step per bit
    end
    return v;
endfunction

`endif

// File: dv/banked_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module banked_mem_tb;

    localparam int LANES = banked_mem_pkg::LANES_DEF;

    // cycles per phase
    localparam int RESET_CYC    = 3;
    localparam int ZERO_RD_CYC  = 20;
    localparam int FILL_CYC     = 40;
    localparam int READBACK_CYC = 40;
    localparam int SAME_REPS    = 10;
    localparam int COLL_REPS    = 8;
    localparam int IDLE_WR_CYC  = 20;
    localparam int MIX_CYC      = 400;
    localparam int PLANNED_CYC  = RESET_CYC + ZERO_RD_CYC + FILL_CYC + READBACK_CYC
                                + 2 * SAME_REPS + 2 * COLL_REPS + IDLE_WR_CYC + MIX_CYC;

    logic                      clk;
    logic                      rst;
    logic                      rd_en;
    logic                      wr_en;
    banked_mem_pkg::bank_idx_t rd_bank [LANES];
    banked_mem_pkg::addr_t     rd_addr [LANES];
    banked_mem_pkg::bank_idx_t wr_bank [LANES];
    banked_mem_pkg::addr_t     wr_addr [LANES];
    banked_mem_pkg::data_t     wr_data [LANES];
    banked_mem_pkg::data_t     rd_data [LANES];
    banked_mem_pkg::bank_idx_t rd_bank_out [LANES];
    banked_mem_pkg::addr_t     rd_addr_out [LANES];
    logic                      rd_valid;

    int          err_count;
    logic [31:0] lfsr_state;
    banked_mem_pkg::data_t last_wr;
    logic [1:0]  op;

    `include "banked_mem_tb_check.svh"

    banked_mem_top #(
        .LANES (LANES)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .rd_en       (rd_en),
        .rd_bank     (rd_bank),
        .rd_addr     (rd_addr),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_data     (rd_data),
        .rd_bank_out (rd_bank_out),
        .rd_addr_out (rd_addr_out),
        .rd_valid    (rd_valid)
    );

    always #5 clk = ~clk;

    task automatic fail_stop();
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    // narrow keeps addresses in the low 8 words so reads hit earlier writes
    task automatic set_request(input bit rd, input bit wr, input bit narrow);
        rd_en = rd;
        wr_en = wr;
        for (int l = 0; l < LANES; l++) begin
            rd_bank[l] = banked_mem_pkg::bank_idx_t'(take_bits(4));
            rd_addr[l] = banked_mem_pkg::addr_t'(narrow ? take_bits(3) : take_bits(7));
            wr_bank[l] = banked_mem_pkg::bank_idx_t'(take_bits(4));
            wr_addr[l] = banked_mem_pkg::addr_t'(narrow ? take_bits(3) : take_bits(7));
            wr_data[l] = banked_mem_pkg::data_t'(take_bits(16));
        end
    endtask

    task automatic run_cycle();
        model_step();
        @(posedge clk);
        #1;
        check_valid(rd_valid, exp_valid);
        for (int l = 0; l < LANES; l++) begin
            check_data("rd_data", l, rd_data[l], exp_data[l]);
            check_bank("rd_bank_out", l, rd_bank_out[l], exp_bank[l]);
            check_addr("rd_addr_out", l, rd_addr_out[l], exp_addr[l]);
        end
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial begin
        #(PLANNED_CYC * 20 + 500);
        $display("timeout: the test sequence did not finish in time");
        fail_stop();
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        err_count  = 0;
        lfsr_state = 32'had77;
        clk = 1'b0;
        rst = 1'b1;
        set_request(1'b0, 1'b0, 1'b0);
        model_clear();
        repeat (RESET_CYC) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (ZERO_RD_CYC) begin    // array is clear after reset
            set_request(1'b1, 1'b0, 1'b0);
            run_cycle();
        end
        repeat (FILL_CYC) begin
            set_request(1'b0, 1'b1, 1'b1);
            run_cycle();
        end
        repeat (READBACK_CYC) begin
            set_request(1'b1, 1'b0, 1'b1);
            run_cycle();
        end

        repeat (SAME_REPS) begin    // same words read and written, then read again
            set_request(1'b1, 1'b1, 1'b1);
            wr_bank = rd_bank;
            wr_addr = rd_addr;
            run_cycle();
            wr_en = 1'b0;
            run_cycle();
        end

        repeat (COLL_REPS) begin    // every lane writes one word
            set_request(1'b0, 1'b1, 1'b0);
            for (int l = 0; l < LANES; l++) begin
                wr_bank[l] = wr_bank[0];
                wr_addr[l] = wr_addr[0];
            end
            last_wr = wr_data[LANES-1];
            run_cycle();
            rd_en   = 1'b1;
            wr_en   = 1'b0;
            rd_bank = wr_bank;
            rd_addr = wr_addr;
            run_cycle();
            for (int l = 0; l < LANES; l++) begin
                check_data("rd_data", l, rd_data[l], last_wr);
            end
        end

        repeat (IDLE_WR_CYC) begin    // outputs stay zero while writing
            set_request(1'b0, 1'b1, 1'b1);
            run_cycle();
        end

        repeat (MIX_CYC) begin
            op = 2'(take_bits(2));
            set_request(op[0], op[1], 1'b1);
            run_cycle();
        end

        if (err_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_stop();
        end
    end

endmodule

`default_nettype wire

// File: banked_mem_top.f
+incdir+dv
rtl/banked_mem_pkg.sv
rtl/lane_req_if.sv
rtl/mem_bank.sv
rtl/read_crossbar.sv
rtl/banked_mem_top.sv
dv/banked_mem_tb.sv

// File: Bender.yml
package:
  name: banked_mem

sources:
  - files:
      - rtl/banked_mem_pkg.sv
      - rtl/lane_req_if.sv
      - rtl/mem_bank.sv
      - rtl/read_crossbar.sv
      - rtl/banked_mem_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/banked_mem_tb.sv
